// File: Makefile
VERILATOR ?= verilator
TOP       := mem_stage_tb
FILELIST  := mem_stage_top.f
VFLAGS    := --binary --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: data_mem.sv
//////////////////////////////////////////////////////////////////////
// data memory: word array with one-cycle stores and a stalling,
// counted load path
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module data_mem import mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        is_load,
    input  logic        is_store,
    input  logic [1:0]  access_size,
    input  logic        load_unsigned,
    input  logic [31:0] address,
    input  logic [31:0] store_data,
    output logic [31:0] load_data,
    output logic        load_valid,
    output logic        stall
);

    logic [31:0] mem [MEM_WORDS];

    logic [$clog2(MEM_WORDS)-1:0]         word_index;
    logic [1:0]                           byte_offset;
    logic [31:0]                          addressed_word;
    logic [31:0]                          merged_word;
    logic [31:0]                          extracted_value;
    logic [$clog2(RETRIEVE_CYCLES+1)-1:0] retrieve_count;

    // high address bits beyond the array are ignored
    assign word_index     = address[$clog2(MEM_WORDS)+1:2];
    assign byte_offset    = address[1:0];
    assign addressed_word = mem[word_index];

    // hold the pipeline until the load result is out
    assign stall = is_load && !load_valid;

    store_lane_merge u_store_lane_merge (
        .old_word    (addressed_word),
        .byte_offset (byte_offset),
        .access_size (access_size),
        .store_data  (store_data),
        .new_word    (merged_word)
    );

    load_lane_extract u_load_lane_extract (
        .word          (addressed_word),
        .byte_offset   (byte_offset),
        .access_size   (access_size),
        .load_unsigned (load_unsigned),
        .value         (extracted_value)
    );

    // store path, memory cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= 32'h0;
            end
        end else if (is_store) begin
            mem[word_index] <= merged_word;
        end
    end

    // load path
    // count RETRIEVE_CYCLES edges, then register the result for one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            retrieve_count <= '0;
            load_valid     <= 1'b0;
            load_data      <= 32'h0;
        end else if (is_load && retrieve_count == RETRIEVE_CYCLES) begin
            retrieve_count <= '0;
            load_valid     <= 1'b1;
            load_data      <= extracted_value;
        end else if (is_load) begin
            // also restarts a load held past its valid cycle
            retrieve_count <= retrieve_count + 1'b1;
            load_valid     <= 1'b0;
            load_data      <= 32'h0;
        end else begin
            retrieve_count <= '0;
            load_valid     <= 1'b0;
            load_data      <= 32'h0;
        end
    end

endmodule

// File: load_lane_extract.sv
//////////////////////////////////////////////////////////////////////
// load extract: picks the addressed byte or halfword and extends it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module load_lane_extract import mem_pkg::*; (
    input  logic [31:0] word,
    input  logic [1:0]  byte_offset,
    input  logic [1:0]  access_size,
    input  logic        load_unsigned,
    output logic [31:0] value
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // lane selection
    assign sel_byte = word[{byte_offset, 3'b000} +: 8];
    assign sel_half = word[{byte_offset[1], 4'b0000} +: 16];

    always_comb begin
        case (access_size)
            SIZE_BYTE: begin
                if (load_unsigned) begin
                    value = {24'b0, sel_byte};
                end else begin
                    value = {{24{sel_byte[7]}}, sel_byte};
                end
            end
            SIZE_HALF: begin
                if (load_unsigned) begin
                    value = {16'b0, sel_half};
                end else begin
                    value = {{16{sel_half[15]}}, sel_half};
                end
            end
            default: begin
                // full word, no extension needed
                value = word;
            end
        endcase
    end

endmodule

// File: mem_op_decode.sv
//////////////////////////////////////////////////////////////////////
// memory op decoder: one-hot instruction to load/store, size, sign
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_op_decode import mem_pkg::*; (
    input  logic [63:0] instruction,
    output logic        is_load,
    output logic        is_store,
    output logic [1:0]  access_size,
    output logic        load_unsigned
);

    always_comb begin
        // unknown codes are not memory operations
        is_load       = 1'b0;
        is_store      = 1'b0;
        access_size   = SIZE_WORD;
        load_unsigned = 1'b0;
        case (instruction)
            INST_LB: begin
                is_load     = 1'b1;
                access_size = SIZE_BYTE;
            end
            INST_LH: begin
                is_load     = 1'b1;
                access_size = SIZE_HALF;
            end
            INST_LW: begin
                is_load     = 1'b1;
                access_size = SIZE_WORD;
            end
            INST_LBU: begin
                is_load       = 1'b1;
                access_size   = SIZE_BYTE;
                load_unsigned = 1'b1;
            end
            INST_LHU: begin
                is_load       = 1'b1;
                access_size   = SIZE_HALF;
                load_unsigned = 1'b1;
            end
            INST_SB: begin
                is_store    = 1'b1;
                access_size = SIZE_BYTE;
            end
            INST_SH: begin
                is_store    = 1'b1;
                access_size = SIZE_HALF;
            end
            INST_SW: begin
                is_store    = 1'b1;
                access_size = SIZE_WORD;
            end
            default: begin
                is_load  = 1'b0;
                is_store = 1'b0;
            end
        endcase
    end

endmodule

// File: mem_pkg.sv
//////////////////////////////////////////////////////////////////////
// memory stage definitions: instruction codes, memory size,
// retrieval delay and access-size encodings
//////////////////////////////////////////////////////////////////////

package mem_pkg;

    // one-hot instruction codes, one set bit per memory operation
    localparam logic [63:0] INST_LB  = 64'd1 << 10;
    localparam logic [63:0] INST_LH  = 64'd1 << 11;
    localparam logic [63:0] INST_LW  = 64'd1 << 12;
    localparam logic [63:0] INST_LBU = 64'd1 << 13;
    localparam logic [63:0] INST_LHU = 64'd1 << 14;
    localparam logic [63:0] INST_SB  = 64'd1 << 15;
    localparam logic [63:0] INST_SH  = 64'd1 << 16;
    localparam logic [63:0] INST_SW  = 64'd1 << 17;

    // data memory depth in 32-bit words
    // word index comes from address bits 9:2
    localparam int MEM_WORDS = 256;

    // cycles a load waits before the result is registered
    localparam int RETRIEVE_CYCLES = 4;

    // access size encodings
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

endpackage

// File: mem_stage_asserts.sv
//////////////////////////////////////////////////////////////////////
// memory stage checker: stall and load-valid rules on data_mem
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_stage_asserts import mem_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        load_valid,
    input logic [31:0] load_data
);

    int stall_run;

    // consecutive stalled cycles of the current load
    always_ff @(posedge clk) begin
        if (reset || !stall) begin
            stall_run <= 0;
        end else begin
            stall_run <= stall_run + 1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(stall && load_valid))
        else $error("stall and load_valid are high in the same cycle");

    assert property (@(posedge clk) disable iff (reset) !load_valid |-> load_data == 32'h0)
        else $error("load_data is not zero while load_valid is low");

    // a stalled load stays stalled until its result is out
    assert property (@(posedge clk) disable iff (reset) stall |=> stall || load_valid)
        else $error("stall dropped before load_valid rose");

    assert property (@(posedge clk) disable iff (reset) stall_run <= RETRIEVE_CYCLES + 1)
        else $error("load_valid did not rise within the retrieval delay");

    assert property (@(posedge clk) reset |=> !stall && !load_valid)
        else $error("stall or load_valid high right after reset");

endmodule

bind data_mem mem_stage_asserts u_mem_stage_asserts (.*);

// File: mem_stage_tb.sv
//////////////////////////////////////////////////////////////////////
// memory stage testbench: reference memory model, directed and random ops
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_stage_tb import mem_pkg::*; ();

    localparam int LOAD_TIMEOUT = 20;

    logic        clk;
    logic        reset;
    logic [63:0] instruction;
    logic [31:0] address;
    logic [31:0] store_data;
    logic [31:0] load_data;
    logic        load_valid;
    logic        stall;

    logic [31:0] model [MEM_WORDS];
    logic [31:0] expected_q [$];
    logic [63:0] op_codes [8];
    logic [31:0] rng_state;
    int          checked_loads;

    always #10 clk = ~clk;

    mem_stage_top u_mem_stage_top (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .address     (address),
        .store_data  (store_data),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .stall       (stall)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [1:0] size_of(input logic [63:0] code);
        if (code == INST_LB || code == INST_LBU || code == INST_SB) begin
            return SIZE_BYTE;
        end else if (code == INST_LH || code == INST_LHU || code == INST_SH) begin
            return SIZE_HALF;
        end
        return SIZE_WORD;
    endfunction

    function automatic logic is_load_code(input logic [63:0] code);
        return code == INST_LB || code == INST_LH || code == INST_LW ||
               code == INST_LBU || code == INST_LHU;
    endfunction

    // byte lanes given by size and offset take the new data
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [1:0] off,
                                                input logic [1:0] size, input logic [31:0] data);
        logic [31:0] mask;
        logic [31:0] placed;
        case (size)
            SIZE_BYTE: begin
                mask   = 32'hff << (8 * off);
                placed = (data & 32'hff) << (8 * off);
            end
            SIZE_HALF: begin
                mask   = 32'hffff << (16 * off[1]);
                placed = (data & 32'hffff) << (16 * off[1]);
            end
            default: begin
                mask   = 32'hffff_ffff;
                placed = data;
            end
        endcase
        return (old & ~mask) | placed;
    endfunction

    // expected load result from a model word
    function automatic logic [31:0] expected_load(input logic [31:0] word, input logic [1:0] off,
                                                  input logic [1:0] size, input logic uns);
        logic [31:0] shifted;
        case (size)
            SIZE_BYTE: begin
                shifted = word >> (8 * off);
                return uns ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                shifted = word >> (16 * off[1]);
                return uns ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
            end
            default: return word;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("[ERROR] %s expected %h got %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // stores, invalid codes and idle cycles all take one cycle
    task automatic run_one_cycle_op(input logic [63:0] code, input logic [31:0] addr,
                                    input logic [31:0] data);
        instruction = code;
        address     = addr;
        store_data  = data;
        if (code == INST_SB || code == INST_SH || code == INST_SW) begin
            model[addr[9:2]] = merge_store(model[addr[9:2]], addr[1:0], size_of(code), data);
        end
        @(negedge clk);
        check_equal("stall", 32'h0, stall);
        check_equal("load_valid", 32'h0, load_valid);
    endtask

    task automatic run_load(input logic [63:0] code, input logic [31:0] addr);
        int edges;
        instruction = code;
        address     = addr;
        expected_q.push_back(expected_load(model[addr[9:2]], addr[1:0], size_of(code),
                                           code == INST_LBU || code == INST_LHU));
        edges = 0;
        // stall is combinational and shows before the first edge
        #5;
        if (!load_valid) begin
            check_equal("stall", 32'h1, stall);
        end
        do begin
            @(negedge clk);
            edges++;
            if (!load_valid) begin
                check_equal("stall", 32'h1, stall);
            end
        end while (!load_valid && edges < LOAD_TIMEOUT);
        assert (load_valid) else begin
            $display("load_valid never arrived for the load at address %h", addr);
            stop_on_error();
        end
        assert (edges == RETRIEVE_CYCLES + 1) else begin
            $display("load_valid came after %0d rising edges instead of %0d",
                     edges, RETRIEVE_CYCLES + 1);
            stop_on_error();
        end
        check_equal("stall", 32'h0, stall);
    endtask

    task automatic run_op(input logic [63:0] code, input logic [31:0] addr,
                          input logic [31:0] data);
        if (is_load_code(code)) begin
            run_load(code, addr);
        end else begin
            run_one_cycle_op(code, addr, data);
        end
    endtask

    // every load result checked against the queued expectation
    always @(negedge clk) begin : compare_loads
        logic [31:0] expected_value;
        if (!reset && load_valid) begin
            assert (expected_q.size() > 0) else begin
                $display("load_valid was raised with no load pending");
                stop_on_error();
            end
            expected_value = expected_q.pop_front();
            assert (load_data == expected_value) else begin
                $display("[ERROR] load_data expected %h got %h", expected_value, load_data);
                stop_on_error();
            end
            checked_loads++;
        end
    end

    initial begin
        int          pick;
        logic [63:0] code;
        logic [31:0] addr;
        logic [31:0] data;
        clk           = 1'b0;
        reset         = 1'b1;
        instruction   = 64'h0;
        address       = 32'h0;
        store_data    = 32'h0;
        rng_state     = 32'h2eed_5a6f;
        checked_loads = 0;
        op_codes = '{INST_LB, INST_LH, INST_LW, INST_LBU, INST_LHU, INST_SB, INST_SH, INST_SW};
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = 32'h0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_equal("stall", 32'h0, stall);
        check_equal("load_valid", 32'h0, load_valid);
        check_equal("load_data", 32'h0, load_data);

        // cleared memory
        for (int i = 0; i < 4; i++) begin
            run_load(INST_LW, i * 32'h144);
        end

        // word round trip with aliased high address bits
        run_one_cycle_op(INST_SW, 32'h0000_0010, 32'hdead_beef);
        run_one_cycle_op(INST_SW, 32'h0000_0410, 32'h1234_5678);
        run_one_cycle_op(INST_SW, 32'h0000_03fc, 32'hcafe_f00d);
        run_one_cycle_op(INST_SW, 32'hffff_fc00, 32'h8765_4321);
        run_load(INST_LW, 32'h0000_0010);
        run_load(INST_LW, 32'h0000_03fc);
        run_load(INST_LW, 32'h0000_0000);
        run_load(INST_LW, 32'h8000_0010);

        // byte and halfword lanes
        run_one_cycle_op(INST_SW, 32'h20, 32'h0102_0304);
        for (int off = 0; off < 4; off++) begin
            run_one_cycle_op(INST_SB, 32'h20 + off, 32'h5a5a_5a80 + off);
            run_load(INST_LW, 32'h20);
        end
        run_one_cycle_op(INST_SW, 32'h24, 32'haabb_ccdd);
        run_one_cycle_op(INST_SH, 32'h24, 32'h1111_8001);
        run_load(INST_LW, 32'h24);
        run_one_cycle_op(INST_SH, 32'h26, 32'h2222_7ffe);
        run_load(INST_LW, 32'h24);
        // halfword offset bit 0 is ignored
        run_one_cycle_op(INST_SH, 32'h27, 32'h3333_c3c3);
        run_load(INST_LW, 32'h24);

        // sign and zero extension
        run_one_cycle_op(INST_SW, 32'h30, 32'h80ff_7f01);
        run_one_cycle_op(INST_SW, 32'h34, 32'h7fff_8000);
        for (int off = 0; off < 4; off++) begin
            run_load(INST_LB, 32'h30 + off);
            run_load(INST_LBU, 32'h30 + off);
            run_load(INST_LB, 32'h34 + off);
            run_load(INST_LBU, 32'h34 + off);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_load(INST_LH, 32'h30 + off);
            run_load(INST_LHU, 32'h30 + off);
            run_load(INST_LH, 32'h34 + off);
            run_load(INST_LHU, 32'h34 + off);
        end

        // random mix over sixteen words with invalid codes
        for (int n = 0; n < 300; n++) begin
            rng_state = lcg_next(rng_state);
            pick      = rng_state[31:16] % 10;
            if (pick < 8) begin
                code = op_codes[pick];
            end else if (rng_state[9:8] == 2'd0) begin
                code = 64'h0;
            end else if (rng_state[9:8] == 2'd1) begin
                code = INST_LB | INST_SH;
            end else begin
                code = 64'd1 << (18 + rng_state[15:10] % 46);
            end
            rng_state = lcg_next(rng_state);
            addr      = rng_state & 32'hffff_f03f;
            rng_state = lcg_next(rng_state);
            data      = rng_state;
            run_op(code, addr, data);
        end
        run_one_cycle_op(64'h0, 32'h0, 32'h0);

        if (expected_q.size() != 0 || checked_loads == 0) begin
            $display("%0d loads never returned a result", expected_q.size());
            stop_on_error();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: mem_stage_top.f
mem_pkg.sv
mem_op_decode.sv
store_lane_merge.sv
load_lane_extract.sv
data_mem.sv
mem_stage_top.sv
mem_stage_asserts.sv
mem_stage_tb.sv

// File: mem_stage_top.sv
//////////////////////////////////////////////////////////////////////
// memory stage top: op decoder feeding the data memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_stage_top (
    input  logic        clk,
    input  logic        reset,
    input  logic [63:0] instruction,
    input  logic [31:0] address,
    input  logic [31:0] store_data,
    output logic [31:0] load_data,
    output logic        load_valid,
    output logic        stall
);

    logic       is_load;
    logic       is_store;
    logic [1:0] access_size;
    logic       load_unsigned;

    // decode is purely combinational
    mem_op_decode u_mem_op_decode (
        .instruction   (instruction),
        .is_load       (is_load),
        .is_store      (is_store),
        .access_size   (access_size),
        .load_unsigned (load_unsigned)
    );

    data_mem u_data_mem (
        .clk           (clk),
        .reset         (reset),
        .is_load       (is_load),
        .is_store      (is_store),
        .access_size   (access_size),
        .load_unsigned (load_unsigned),
        .address       (address),
        .store_data    (store_data),
        .load_data     (load_data),
        .load_valid    (load_valid),
        .stall         (stall)
    );

endmodule

// File: store_lane_merge.sv
//////////////////////////////////////////////////////////////////////
// store merge: places byte or halfword store data into the old word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module store_lane_merge import mem_pkg::*; (
    input  logic [31:0] old_word,
    input  logic [1:0]  byte_offset,
    input  logic [1:0]  access_size,
    input  logic [31:0] store_data,
    output logic [31:0] new_word
);

    always_comb begin
        // lanes not written keep their old contents
        new_word = old_word;
        case (access_size)
            SIZE_BYTE: begin
                new_word[{byte_offset, 3'b000} +: 8] = store_data[7:0];
            end
            SIZE_HALF: begin
                // offset bit 0 ignored, no misaligned trap
                new_word[{byte_offset[1], 4'b0000} +: 16] = store_data[15:0];
            end
            SIZE_WORD: begin
                new_word = store_data;
            end
            default: begin
                new_word = old_word;
            end
        endcase
    end

endmodule
